// File: dv/tb_mbuf_adapter.sv
`timescale 1ns/1ps

module tb_mbuf_adapter;

    localparam int NUM_BANKS    = 4;
    localparam int BANK_DEPTH   = 16;
    localparam int DATA_W       = 32;
    localparam int BE_W         = DATA_W / 8;
    localparam int ADDR_W       = 4;
    localparam int TOTAL_FRAMES = 58;

    logic              acc_clk;
    logic              aresetn;
    logic [DATA_W-1:0] s_axis_tdata;
    logic              s_axis_tvalid;
    logic              s_axis_tlast;
    logic              s_axis_tready;
    logic [DATA_W-1:0] m_axis_tdata;
    logic              m_axis_tvalid;
    logic              m_axis_tlast;
    logic              m_axis_tready;
    logic              acc_start_ready;
    logic              acc_done;
    logic              acc_en;
    logic [BE_W-1:0]   acc_we;
    logic [ADDR_W-1:0] acc_addr;
    logic [DATA_W-1:0] acc_wdata;
    logic [DATA_W-1:0] acc_rdata;

    int errors;
    int checks;
    int tests;
    int frames_in;
    int frames_out;
    int beat_idx;
    int ready_pct;
    int be_mode;
    logic acc_hold;

    // Words in input order, lengths per frame, and predicted output
    logic [DATA_W-1:0] acc_in_q  [$];
    int                acc_len_q [$];
    logic [DATA_W-1:0] exp_words [$];
    int                exp_lens  [$];

    mbuf_adapter_top #(
        .NUM_BANKS  (NUM_BANKS),
        .BANK_DEPTH (BANK_DEPTH),
        .DATA_W     (DATA_W)
    ) u_mbuf_adapter_top (
        .acc_clk         (acc_clk),
        .aresetn         (aresetn),
        .s_axis_tdata    (s_axis_tdata),
        .s_axis_tvalid   (s_axis_tvalid),
        .s_axis_tlast    (s_axis_tlast),
        .s_axis_tready   (s_axis_tready),
        .m_axis_tdata    (m_axis_tdata),
        .m_axis_tvalid   (m_axis_tvalid),
        .m_axis_tlast    (m_axis_tlast),
        .m_axis_tready   (m_axis_tready),
        .acc_start_ready (acc_start_ready),
        .acc_done        (acc_done),
        .acc_en          (acc_en),
        .acc_we          (acc_we),
        .acc_addr        (acc_addr),
        .acc_wdata       (acc_wdata),
        .acc_rdata       (acc_rdata)
    );

    initial begin
        acc_clk = 1'b0;
        forever #5 acc_clk = ~acc_clk;
    end

    initial begin
        repeat (TOTAL_FRAMES * 200) @(posedge acc_clk);
        $display("Timeout after %0d cycles, output frames %0d of %0d",
                 TOTAL_FRAMES * 200, frames_out, frames_in);
        $display("SIMULATION FAILED");
        $finish;
    end

    task automatic check_value(input string name, input logic [DATA_W-1:0] exp,
                               input logic [DATA_W-1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[ERROR] %s expected %h got %h", name, exp, act);
        end
    endtask

    // New bytes where enabled, old bytes elsewhere
    function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_w,
                                                      input logic [DATA_W-1:0] new_w,
                                                      input logic [BE_W-1:0] be);
        logic [DATA_W-1:0] res;
        res = old_w;
        for (int b = 0; b < BE_W; b++) begin
            if (be[b]) begin
                res[b*8 +: 8] = new_w[b*8 +: 8];
            end
        end
        return res;
    endfunction

    function automatic logic [BE_W-1:0] pick_enables();
        if (be_mode == 1 || ($urandom % 4) == 0) begin
            return BE_W'($urandom);
        end
        return '1;
    endfunction

    task automatic send_frame(input int len);
        logic [DATA_W-1:0] word;
        acc_len_q.push_back(len);
        for (int i = 0; i < len; i++) begin
            word = $urandom;
            acc_in_q.push_back(word);
            if (($urandom % 4) == 0) begin
                @(posedge acc_clk);
                s_axis_tvalid <= 1'b0;
                repeat ($urandom % 3) @(posedge acc_clk);
            end
            @(posedge acc_clk);
            s_axis_tvalid <= 1'b1;
            s_axis_tdata  <= word;
            s_axis_tlast  <= (i == len - 1);
            @(negedge acc_clk);
            while (s_axis_tready !== 1'b1) @(negedge acc_clk);
        end
        frames_in++;
        @(posedge acc_clk);
        s_axis_tvalid <= 1'b0;
        s_axis_tlast  <= 1'b0;
    endtask

    // Read, add one, write back with the chosen byte enables
    task automatic process_bank();
        int                len;
        logic [DATA_W-1:0] orig;
        logic [DATA_W-1:0] rdata;
        logic [BE_W-1:0]   be;
        if (acc_len_q.size() == 0) begin
            errors++;
            $display("acc_start_ready went high with no frame sent");
            acc_hold = 1'b1;
            return;
        end
        len = acc_len_q.pop_front();
        exp_lens.push_back(len);
        for (int i = 0; i < len; i++) begin
            orig = acc_in_q.pop_front();
            @(posedge acc_clk);
            acc_en   <= 1'b1;
            acc_we   <= '0;
            acc_addr <= ADDR_W'(i);
            @(posedge acc_clk);
            acc_en <= 1'b0;
            @(negedge acc_clk);
            rdata = acc_rdata;
            check_value("acc_rdata", orig, rdata);
            be = pick_enables();
            @(posedge acc_clk);
            acc_en    <= 1'b1;
            acc_we    <= be;
            acc_wdata <= rdata + 1'b1;
            exp_words.push_back(merge_bytes(orig, orig + 1'b1, be));
        end
        @(posedge acc_clk);
        acc_en   <= 1'b0;
        acc_we   <= '0;
        acc_done <= 1'b1;
        @(posedge acc_clk);
        acc_done <= 1'b0;
    endtask

    initial begin : accelerator
        acc_done  = 1'b0;
        acc_en    = 1'b0;
        acc_we    = '0;
        acc_addr  = '0;
        acc_wdata = '0;
        wait (aresetn === 1'b1);
        forever begin
            @(negedge acc_clk);
            if (!acc_hold && acc_start_ready === 1'b1) begin
                process_bank();
            end
        end
    end

    task automatic check_beat();
        logic [DATA_W-1:0] exp_word;
        logic              exp_last;
        if (exp_words.size() == 0 || exp_lens.size() == 0) begin
            errors++;
            $display("Output beat %h arrived with no frame expected", m_axis_tdata);
            return;
        end
        exp_word = exp_words.pop_front();
        exp_last = (beat_idx == exp_lens[0] - 1);
        check_value("m_axis_tdata", exp_word, m_axis_tdata);
        check_value("m_axis_tlast", DATA_W'(exp_last), DATA_W'(m_axis_tlast));
        if (exp_last) begin
            void'(exp_lens.pop_front());
            beat_idx = 0;
            frames_out++;
        end else begin
            beat_idx++;
        end
    endtask

    initial begin : output_sink
        m_axis_tready = 1'b0;
        wait (aresetn === 1'b1);
        forever begin
            @(posedge acc_clk);
            m_axis_tready <= (($urandom % 100) < ready_pct);
            @(negedge acc_clk);
            if (m_axis_tvalid === 1'b1 && m_axis_tready === 1'b1) begin
                check_beat();
            end
        end
    end

    task automatic wait_drained();
        while (frames_out < frames_in) @(negedge acc_clk);
        repeat (4) @(negedge acc_clk);
        // All banks free again with no stray output beat
        check_value("m_axis_tvalid", '0, DATA_W'(m_axis_tvalid));
        check_value("s_axis_tready", 1, DATA_W'(s_axis_tready));
    endtask

    task automatic report_test(input string name, input int n, input int errs);
        tests++;
        $display("test %s: %0d frames, %0d errors", name, n, errs);
    endtask

    task automatic run_frames(input string name, input int n, input int pct, input int mode);
        int start_err;
        start_err = errors;
        ready_pct = pct;
        be_mode   = mode;
        for (int f = 0; f < n; f++) begin
            send_frame(1 + int'($urandom % BANK_DEPTH));
            repeat ($urandom % 6) @(posedge acc_clk);
        end
        wait_drained();
        report_test(name, n, errors - start_err);
    endtask

    // Accelerator stalls until every bank is filled
    task automatic run_holdoff(input int n);
        int start_err;
        int base;
        start_err = errors;
        base      = frames_in;
        ready_pct = 100;
        be_mode   = 0;
        acc_hold  = 1'b1;
        fork
            begin
                for (int f = 0; f < n; f++) begin
                    send_frame(1 + int'($urandom % BANK_DEPTH));
                end
            end
            begin
                while (frames_in < base + NUM_BANKS) @(negedge acc_clk);
                repeat (4) @(negedge acc_clk);
                for (int c = 0; c < 30; c++) begin
                    @(negedge acc_clk);
                    check_value("s_axis_tready", '0, DATA_W'(s_axis_tready));
                    check_value("acc_start_ready", 1, DATA_W'(acc_start_ready));
                end
                acc_hold = 1'b0;
            end
        join
        wait_drained();
        report_test("acc_holdoff", n, errors - start_err);
    endtask

    initial begin
        void'($urandom(32'hb71a));
        errors        = 0;
        checks        = 0;
        tests         = 0;
        frames_in     = 0;
        frames_out    = 0;
        beat_idx      = 0;
        ready_pct     = 100;
        be_mode       = 0;
        acc_hold      = 1'b0;
        aresetn       = 1'b0;
        s_axis_tdata  = '0;
        s_axis_tvalid = 1'b0;
        s_axis_tlast  = 1'b0;
        repeat (3) @(posedge acc_clk);
        aresetn <= 1'b1;

        @(negedge acc_clk);
        check_value("s_axis_tready", 1, DATA_W'(s_axis_tready));
        check_value("m_axis_tvalid", '0, DATA_W'(m_axis_tvalid));
        check_value("m_axis_tlast", '0, DATA_W'(m_axis_tlast));
        check_value("acc_start_ready", '0, DATA_W'(acc_start_ready));
        report_test("reset_values", 0, errors);

        run_frames("random_traffic", 24, 80, 0);
        run_frames("backpressure", 16, 20, 0);
        run_frames("partial_be", 12, 60, 1);
        run_holdoff(6);

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: logic/bank_port_if.sv
`timescale 1ns/1ps

interface bank_port_if #(
    parameter int ADDR_W = 4,
    parameter int DATA_W = 32
);

    logic                en;
    logic [DATA_W/8-1:0] we;
    logic [ADDR_W-1:0]   addr;
    logic [DATA_W-1:0]   wdata;
    logic [DATA_W-1:0]   rdata;

    // Requester side
    modport master (
        output en, we, addr, wdata,
        input  rdata
    );

    // Memory side
    modport bank (
        input  en, we, addr, wdata,
        output rdata
    );

endinterface

// File: logic/bank_router.sv
`timescale 1ns/1ps

module bank_router #(
    parameter int NUM_BANKS = mbuf_pkg::DEF_NUM_BANKS,
    parameter int DATA_W    = mbuf_pkg::DEF_DATA_W,
    localparam int SEL_W    = (NUM_BANKS > 1) ? $clog2(NUM_BANKS) : 1
) (
    input  logic             acc_clk,
    input  logic [SEL_W-1:0] fill_sel,
    input  logic [SEL_W-1:0] acc_sel,
    input  logic [SEL_W-1:0] drain_sel,
    bank_port_if.bank        wr,
    bank_port_if.bank        acc,
    bank_port_if.bank        rd,
    bank_port_if.master      banks [NUM_BANKS]
);

    logic [SEL_W-1:0]  fill_sel_q;
    logic [SEL_W-1:0]  acc_sel_q;
    logic [SEL_W-1:0]  drain_sel_q;
    logic [DATA_W-1:0] bank_rdata [NUM_BANKS];

    for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
        logic wr_hit;
        logic acc_hit;
        logic rd_hit;

        assign wr_hit  = wr.en && (fill_sel == SEL_W'(i));
        assign acc_hit = acc.en && (acc_sel == SEL_W'(i));
        assign rd_hit  = rd.en && (drain_sel == SEL_W'(i));

        // At most one owner hits a given bank
        always_comb begin
            banks[i].en    = 1'b0;
            banks[i].we    = '0;
            banks[i].addr  = '0;
            banks[i].wdata = '0;
            if (wr_hit) begin
                banks[i].en    = 1'b1;
                banks[i].we    = wr.we;
                banks[i].addr  = wr.addr;
                banks[i].wdata = wr.wdata;
            end else if (acc_hit) begin
                banks[i].en    = 1'b1;
                banks[i].we    = acc.we;
                banks[i].addr  = acc.addr;
                banks[i].wdata = acc.wdata;
            end else if (rd_hit) begin
                banks[i].en    = 1'b1;
                banks[i].we    = rd.we;
                banks[i].addr  = rd.addr;
                banks[i].wdata = rd.wdata;
            end
        end

        assign bank_rdata[i] = banks[i].rdata;
    end

    // Selects delayed to match the bank read latency
    always_ff @(posedge acc_clk) begin
        fill_sel_q  <= fill_sel;
        acc_sel_q   <= acc_sel;
        drain_sel_q <= drain_sel;
    end

    assign wr.rdata  = bank_rdata[fill_sel_q];
    assign acc.rdata = bank_rdata[acc_sel_q];
    assign rd.rdata  = bank_rdata[drain_sel_q];

endmodule

// File: logic/buffer_bank.sv
`timescale 1ns/1ps

module buffer_bank #(
    parameter int BANK_DEPTH = mbuf_pkg::DEF_BANK_DEPTH,
    parameter int DATA_W     = mbuf_pkg::DEF_DATA_W
) (
    input logic       acc_clk,
    bank_port_if.bank mem
);

    logic [DATA_W-1:0] ram [BANK_DEPTH];

    // Read data shows the old word during a write
    always_ff @(posedge acc_clk) begin
        if (mem.en) begin
            for (int b = 0; b < DATA_W / 8; b++) begin
                if (mem.we[b]) begin
                    ram[mem.addr][b*8 +: 8] <= mem.wdata[b*8 +: 8];
                end
            end
            mem.rdata <= ram[mem.addr];
        end
    end

endmodule

// File: logic/buffer_ring_ctrl.sv
`timescale 1ns/1ps

module buffer_ring_ctrl #(
    parameter int NUM_BANKS  = mbuf_pkg::DEF_NUM_BANKS,
    parameter int BANK_DEPTH = mbuf_pkg::DEF_BANK_DEPTH,
    localparam int SEL_W     = (NUM_BANKS > 1) ? $clog2(NUM_BANKS) : 1,
    localparam int LEN_W     = $clog2(BANK_DEPTH + 1)
) (
    input  logic             acc_clk,
    input  logic             aresetn,
    input  logic             fill_done,
    input  logic [LEN_W-1:0] fill_len,
    input  logic             acc_done,
    input  logic             drain_done,
    output logic [SEL_W-1:0] fill_sel,
    output logic [SEL_W-1:0] acc_sel,
    output logic [SEL_W-1:0] drain_sel,
    output logic             fill_allow,
    output logic             acc_start_ready,
    output logic             drain_go,
    output logic [LEN_W-1:0] drain_len
);

    import mbuf_pkg::*;

    bank_state_e      bank_state [NUM_BANKS];
    logic [LEN_W-1:0] bank_len   [NUM_BANKS];
    logic [SEL_W-1:0] fill_ptr;
    logic [SEL_W-1:0] acc_ptr;
    logic [SEL_W-1:0] drain_ptr;

    function automatic logic [SEL_W-1:0] next_ptr(input logic [SEL_W-1:0] ptr);
        if (ptr == SEL_W'(NUM_BANKS - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    always_ff @(posedge acc_clk) begin
        if (!aresetn) begin
            fill_ptr  <= '0;
            acc_ptr   <= '0;
            drain_ptr <= '0;
            for (int i = 0; i < NUM_BANKS; i++) begin
                bank_state[i] <= BANK_FREE;
            end
        end else begin
            // Each pulse targets a bank in a different state
            if (fill_done) begin
                bank_state[fill_ptr] <= BANK_FILLED;
                fill_ptr             <= next_ptr(fill_ptr);
            end
            if (acc_done) begin
                bank_state[acc_ptr] <= BANK_PROCESSED;
                acc_ptr             <= next_ptr(acc_ptr);
            end
            if (drain_done) begin
                bank_state[drain_ptr] <= BANK_FREE;
                drain_ptr             <= next_ptr(drain_ptr);
            end
        end
    end

    always_ff @(posedge acc_clk) begin
        if (fill_done) begin
            bank_len[fill_ptr] <= fill_len;
        end
    end

    assign fill_sel  = fill_ptr;
    assign acc_sel   = acc_ptr;
    assign drain_sel = drain_ptr;
    assign drain_len = bank_len[drain_ptr];

    // Writer and reader held off while their pointer moves on
    assign fill_allow      = (bank_state[fill_ptr] == BANK_FREE) && !fill_done;
    assign acc_start_ready = (bank_state[acc_ptr] == BANK_FILLED);
    assign drain_go        = (bank_state[drain_ptr] == BANK_PROCESSED) && !drain_done;

    a_acc_done_legal: assert property (
        @(posedge acc_clk) disable iff (!aresetn)
        acc_done |-> (bank_state[acc_ptr] == BANK_FILLED)
    ) else $error("buffer_ring_ctrl: acc_done without a filled bank");

endmodule

// File: logic/mbuf_adapter_top.sv
`timescale 1ns/1ps

module mbuf_adapter_top #(
    parameter int NUM_BANKS  = mbuf_pkg::DEF_NUM_BANKS,
    parameter int BANK_DEPTH = mbuf_pkg::DEF_BANK_DEPTH,
    parameter int DATA_W     = mbuf_pkg::DEF_DATA_W,
    localparam int ADDR_W    = (BANK_DEPTH > 1) ? $clog2(BANK_DEPTH) : 1
) (
    input  logic                acc_clk,
    input  logic                aresetn,
    input  logic [DATA_W-1:0]   s_axis_tdata,
    input  logic                s_axis_tvalid,
    input  logic                s_axis_tlast,
    output logic                s_axis_tready,
    output logic [DATA_W-1:0]   m_axis_tdata,
    output logic                m_axis_tvalid,
    output logic                m_axis_tlast,
    input  logic                m_axis_tready,
    output logic                acc_start_ready,
    input  logic                acc_done,
    input  logic                acc_en,
    input  logic [DATA_W/8-1:0] acc_we,
    input  logic [ADDR_W-1:0]   acc_addr,
    input  logic [DATA_W-1:0]   acc_wdata,
    output logic [DATA_W-1:0]   acc_rdata
);

    import mbuf_pkg::*;

    localparam int SEL_W = (NUM_BANKS > 1) ? $clog2(NUM_BANKS) : 1;
    localparam int LEN_W = $clog2(BANK_DEPTH + 1);

    logic [SEL_W-1:0] fill_sel;
    logic [SEL_W-1:0] acc_sel;
    logic [SEL_W-1:0] drain_sel;
    logic             fill_allow;
    logic             fill_done;
    logic [LEN_W-1:0] fill_len;
    logic             drain_go;
    logic             drain_done;
    logic [LEN_W-1:0] drain_len;

    bank_port_if #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) wr_if ();
    bank_port_if #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) acc_if ();
    bank_port_if #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) rd_if ();
    bank_port_if #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) bank_if [NUM_BANKS] ();

    // Accelerator memory port
    assign acc_if.en    = acc_en;
    assign acc_if.we    = acc_we;
    assign acc_if.addr  = acc_addr;
    assign acc_if.wdata = acc_wdata;
    assign acc_rdata    = acc_if.rdata;

    stream_writer #(.BANK_DEPTH(BANK_DEPTH), .DATA_W(DATA_W)) u_stream_writer (
        .acc_clk    (acc_clk),
        .aresetn    (aresetn),
        .s_tdata    (s_axis_tdata),
        .s_tvalid   (s_axis_tvalid),
        .s_tlast    (s_axis_tlast),
        .s_tready   (s_axis_tready),
        .fill_allow (fill_allow),
        .fill_done  (fill_done),
        .fill_len   (fill_len),
        .mem        (wr_if)
    );

    buffer_ring_ctrl #(.NUM_BANKS(NUM_BANKS), .BANK_DEPTH(BANK_DEPTH)) u_ring_ctrl (
        .acc_clk         (acc_clk),
        .aresetn         (aresetn),
        .fill_done       (fill_done),
        .fill_len        (fill_len),
        .acc_done        (acc_done),
        .drain_done      (drain_done),
        .fill_sel        (fill_sel),
        .acc_sel         (acc_sel),
        .drain_sel       (drain_sel),
        .fill_allow      (fill_allow),
        .acc_start_ready (acc_start_ready),
        .drain_go        (drain_go),
        .drain_len       (drain_len)
    );

    bank_router #(.NUM_BANKS(NUM_BANKS), .DATA_W(DATA_W)) u_bank_router (
        .acc_clk   (acc_clk),
        .fill_sel  (fill_sel),
        .acc_sel   (acc_sel),
        .drain_sel (drain_sel),
        .wr        (wr_if),
        .acc       (acc_if),
        .rd        (rd_if),
        .banks     (bank_if)
    );

    for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
        buffer_bank #(.BANK_DEPTH(BANK_DEPTH), .DATA_W(DATA_W)) u_buffer_bank (
            .acc_clk (acc_clk),
            .mem     (bank_if[i])
        );
    end

    stream_reader #(.BANK_DEPTH(BANK_DEPTH), .DATA_W(DATA_W)) u_stream_reader (
        .acc_clk    (acc_clk),
        .aresetn    (aresetn),
        .drain_go   (drain_go),
        .drain_len  (drain_len),
        .drain_done (drain_done),
        .m_tdata    (m_axis_tdata),
        .m_tvalid   (m_axis_tvalid),
        .m_tlast    (m_axis_tlast),
        .m_tready   (m_axis_tready),
        .mem        (rd_if)
    );

    // Requesters only touch banks the ring has handed to them
    a_acc_bank_filled: assert property (
        @(posedge acc_clk) disable iff (!aresetn)
        acc_if.en |-> (u_ring_ctrl.bank_state[acc_sel] == BANK_FILLED)
    ) else $error("mbuf_adapter_top: accelerator access to a bank that is not filled");

    a_drain_bank_processed: assert property (
        @(posedge acc_clk) disable iff (!aresetn)
        rd_if.en |-> (u_ring_ctrl.bank_state[drain_sel] == BANK_PROCESSED)
    ) else $error("mbuf_adapter_top: drain read from an unprocessed bank");

endmodule

// File: logic/mbuf_pkg.sv
package mbuf_pkg;

    // Default sizes that the top level overrides
    localparam int DEF_NUM_BANKS  = 4;
    localparam int DEF_BANK_DEPTH = 16;
    localparam int DEF_DATA_W     = 32;

    // Life cycle of one bank in the ring
    typedef enum logic [1:0] {
        BANK_FREE      = 2'd0,
        BANK_FILLED    = 2'd1,
        BANK_PROCESSED = 2'd2
    } bank_state_e;

endpackage

// File: logic/stream_reader.sv
`timescale 1ns/1ps

module stream_reader #(
    parameter int BANK_DEPTH = mbuf_pkg::DEF_BANK_DEPTH,
    parameter int DATA_W     = mbuf_pkg::DEF_DATA_W,
    localparam int ADDR_W    = (BANK_DEPTH > 1) ? $clog2(BANK_DEPTH) : 1,
    localparam int LEN_W     = $clog2(BANK_DEPTH + 1)
) (
    input  logic              acc_clk,
    input  logic              aresetn,
    input  logic              drain_go,
    input  logic [LEN_W-1:0]  drain_len,
    output logic              drain_done,
    output logic [DATA_W-1:0] m_tdata,
    output logic              m_tvalid,
    output logic              m_tlast,
    input  logic              m_tready,
    bank_port_if.master       mem
);

    logic              busy;
    logic              start;
    logic [LEN_W-1:0]  len_q;
    logic [LEN_W-1:0]  rd_addr;
    logic              rd_pend;
    logic              pend_last;
    logic              issue;
    logic              pop;
    logic [1:0]        cnt;
    logic              wr_idx;
    logic              rd_idx;
    logic [DATA_W-1:0] skid_data [2];
    logic              skid_last [2];

    assign start    = !busy && drain_go;
    assign m_tvalid = (cnt != 2'd0);
    assign m_tdata  = skid_data[rd_idx];
    assign m_tlast  = m_tvalid && skid_last[rd_idx];
    assign pop      = m_tvalid && m_tready;

    // Reads in flight plus buffered words never exceed two
    assign issue = busy && (rd_addr < len_q) && (((cnt + 2'(rd_pend)) < 2'd2) || pop);

    assign mem.en    = issue;
    assign mem.we    = '0;
    assign mem.addr  = rd_addr[ADDR_W-1:0];
    assign mem.wdata = '0;

    always_ff @(posedge acc_clk) begin
        if (!aresetn) begin
            busy       <= 1'b0;
            rd_addr    <= '0;
            rd_pend    <= 1'b0;
            cnt        <= 2'd0;
            wr_idx     <= 1'b0;
            rd_idx     <= 1'b0;
            drain_done <= 1'b0;
        end else begin
            drain_done <= pop && m_tlast;
            rd_pend    <= issue;
            cnt        <= cnt + 2'(rd_pend) - 2'(pop);
            if (start) begin
                busy    <= 1'b1;
                rd_addr <= '0;
            end else if (pop && m_tlast) begin
                busy <= 1'b0;
            end
            if (issue) begin
                rd_addr <= rd_addr + 1'b1;
            end
            if (rd_pend) begin
                wr_idx <= ~wr_idx;
            end
            if (pop) begin
                rd_idx <= ~rd_idx;
            end
        end
    end

    // Frame length, last tag and skid entries
    always_ff @(posedge acc_clk) begin
        if (start) begin
            len_q <= drain_len;
        end
        if (issue) begin
            pend_last <= (rd_addr == len_q - 1'b1);
        end
        if (rd_pend) begin
            skid_data[wr_idx] <= mem.rdata;
            skid_last[wr_idx] <= pend_last;
        end
    end

endmodule

// File: logic/stream_writer.sv
`timescale 1ns/1ps

module stream_writer #(
    parameter int BANK_DEPTH = mbuf_pkg::DEF_BANK_DEPTH,
    parameter int DATA_W     = mbuf_pkg::DEF_DATA_W,
    localparam int ADDR_W    = (BANK_DEPTH > 1) ? $clog2(BANK_DEPTH) : 1,
    localparam int LEN_W     = $clog2(BANK_DEPTH + 1)
) (
    input  logic              acc_clk,
    input  logic              aresetn,
    input  logic [DATA_W-1:0] s_tdata,
    input  logic              s_tvalid,
    input  logic              s_tlast,
    output logic              s_tready,
    input  logic              fill_allow,
    output logic              fill_done,
    output logic [LEN_W-1:0]  fill_len,
    bank_port_if.master       mem
);

    logic [LEN_W-1:0] count;
    logic             beat;

    assign s_tready = fill_allow;
    assign beat     = s_tvalid && fill_allow;

    // Accepted beat goes straight into the fill bank
    assign mem.en    = beat;
    assign mem.we    = {(DATA_W/8){beat}};
    assign mem.addr  = count[ADDR_W-1:0];
    assign mem.wdata = s_tdata;

    always_ff @(posedge acc_clk) begin
        if (!aresetn) begin
            count     <= '0;
            fill_done <= 1'b0;
        end else begin
            fill_done <= beat && s_tlast;
            if (beat) begin
                count <= s_tlast ? '0 : count + 1'b1;
            end
        end
    end

    // Length of the frame just closed
    always_ff @(posedge acc_clk) begin
        if (beat && s_tlast) begin
            fill_len <= count + 1'b1;
        end
    end

    a_no_overrun: assert property (
        @(posedge acc_clk) disable iff (!aresetn)
        beat |-> (count < LEN_W'(BANK_DEPTH))
    ) else $error("stream_writer: frame longer than BANK_DEPTH");

endmodule

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f vlog.f \
    --top-module tb_mbuf_adapter \
    -o sim_tb

out=$(./obj_dir/sim_tb)
echo "$out"
echo "$out" | grep -q "SIMULATION PASSED"

// File: vlog.f
logic/mbuf_pkg.sv
logic/bank_port_if.sv
logic/stream_writer.sv
logic/buffer_ring_ctrl.sv
logic/bank_router.sv
logic/buffer_bank.sv
logic/stream_reader.sv
logic/mbuf_adapter_top.sv
dv/tb_mbuf_adapter.sv
